// ==== rtl/colmix_settings.svh ====
`ifndef COLMIX_SETTINGS_SVH
`define COLMIX_SETTINGS_SVH

// palette PROM count, one per video layer
// bak, obj and txt in that order
`define COLMIX_NUM_LAYERS 3

// PROM geometry
// 256 words cover the largest layer address (obj code + pixel)
`define COLMIX_PROM_AW 8
`define COLMIX_PROM_DW 8

// smaller layer addresses are zero-extended up to COLMIX_PROM_AW
// bak uses 5 bits, txt uses 5 bits (top code bit repeated)
// obj uses all 8 bits

// colour word is one PROM data word
// rrr ggg bb from msb to lsb

// object palette data was split over two 4-bit PROMs on the board
// here it is kept as a single 8-bit word

`endif

// ==== rtl/video_pkg.sv ====
`include "colmix_settings.svh"

package video_pkg;

    // layer colour codes as presented by the renderers
    typedef logic [4:0] bak_code_t; // background tile colour
    typedef logic [5:0] obj_code_t; // sprite colour
    typedef logic [1:0] obj_pix_t;  // sprite pixel, 0 is transparent
    typedef logic [3:0] txt_code_t; // text colour

    // palette word, rrr_ggg_bb
    typedef logic [7:0] colour_t;

    // one output channel, blue uses only the top two bits
    typedef logic [2:0] chan3_t;

    // one bit per layer, at most one set
    typedef logic [`COLMIX_NUM_LAYERS-1:0] layer_sel_t;

    // layer positions in layer_sel and in the PROM array
    localparam int BAK_IDX = 0;
    localparam int OBJ_IDX = 1;
    localparam int TXT_IDX = 2;

    // also used as prom_sel values on the programming side

endpackage

// ==== rtl/prom_pkg.sv ====
`include "colmix_settings.svh"

package prom_pkg;

    // programming and read side of the palette PROMs
    typedef logic [`COLMIX_PROM_AW-1:0] prom_addr_t;
    typedef logic [`COLMIX_PROM_DW-1:0] prom_data_t;

    // which PROM a write goes to
    // 0 bak, 1 obj, 2 txt, 3 unused
    typedef logic [1:0] prom_sel_t;

    // words per PROM
    localparam int PROM_DEPTH = 2 ** `COLMIX_PROM_AW;

endpackage

// ==== rtl/layer_fetch.sv ====
`include "colmix_settings.svh"

module layer_fetch
    import video_pkg::*, prom_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,   // one cycle pixel strobe
    // layer inputs
    input  bak_code_t  bak_code,
    input  obj_code_t  obj_code,
    input  obj_pix_t   obj_pix,
    input  txt_code_t  txt_code,
    input  logic       txt_valid, // active low, text shows when low
    // blanking
    input  logic       hblank_n,
    input  logic       vblank_n,
    // programming select
    input  prom_sel_t  prog_sel,
    input  logic       prog_we,
    // to PROMs and mixer
    output prom_addr_t rd_addr [`COLMIX_NUM_LAYERS],
    output logic [`COLMIX_NUM_LAYERS-1:0] we,
    output layer_sel_t layer_sel
);

    layer_sel_t sel_d; // next priority decision

    // read addresses, zero-extended where the code is short
    assign rd_addr[BAK_IDX] = prom_addr_t'(bak_code);
    assign rd_addr[OBJ_IDX] = prom_addr_t'({obj_code, obj_pix}); // code then pixel
    // txt top bit doubled, as the board wired it
    assign rd_addr[TXT_IDX] = prom_addr_t'({txt_code[3], txt_code});

    // write enable decode
    // writes ignore pxl_cen, any clk edge with prog_we high
    always_comb begin
        for (int i = 0; i < `COLMIX_NUM_LAYERS; i++) begin
            we[i] = prog_we && (prog_sel == prom_sel_t'(i));
        end
    end

    // priority, text over object over background
    always_comb begin
        sel_d = '0;
        if (!txt_valid) begin
            sel_d[TXT_IDX] = 1'b1;
        end else if (obj_pix != '0) begin
            sel_d[OBJ_IDX] = 1'b1; // opaque sprite pixel
        end else if (hblank_n && vblank_n) begin
            sel_d[BAK_IDX] = 1'b1; // bg only in active area
        end
        // else nothing visible, sel stays zero
    end

    // decision lines up with the PROM read of the same strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layer_sel <= '0;
        end else if (pxl_cen) begin
            layer_sel <= sel_d;
        end
    end

endmodule

// ==== rtl/palette_prom.sv ====
`include "colmix_settings.svh"

module palette_prom
    import prom_pkg::*;
(
    input  logic       clk,
    input  logic       cen,     // pixel strobe, gates the read only
    input  prom_addr_t rd_addr,
    input  prom_addr_t wr_addr,
    input  prom_data_t data,
    input  logic       we,
    output prom_data_t q
);

    prom_data_t mem [PROM_DEPTH]; // palette contents, loaded through the write port

    // write port
    // free running, not tied to the pixel strobe
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= data;
        end
    end

    // read port, one strobe of latency
    // q holds between strobes
    always_ff @(posedge clk) begin
        if (cen) begin
            q <= mem[rd_addr];
        end
    end

    // same-address write and read on one edge returns the old word

endmodule

// ==== rtl/colour_priority_mix.sv ====
`include "colmix_settings.svh"

module colour_priority_mix
    import video_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    input  logic       vblank_n,  // resampled here, one strobe after layer_fetch
    input  layer_sel_t layer_sel, // registered priority, at most one bit
    input  colour_t    pal [`COLMIX_NUM_LAYERS],
    output chan3_t     red,
    output chan3_t     green,
    output chan3_t     blue       // lsb always zero
);

    colour_t mix_d; // chosen palette word
    colour_t mix_q; // registered output word

    // pick one palette output
    always_comb begin
        if (!vblank_n) begin
            mix_d = '0; // vertical blank forces black
        end else if (layer_sel[TXT_IDX]) begin
            mix_d = pal[TXT_IDX];
        end else if (layer_sel[OBJ_IDX]) begin
            mix_d = pal[OBJ_IDX];
        end else if (layer_sel[BAK_IDX]) begin
            mix_d = pal[BAK_IDX];
        end else begin
            mix_d = '0; // nothing visible
        end
    end

    // output register, strobe N+1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mix_q <= '0;
        end else if (pxl_cen) begin
            mix_q <= mix_d;
        end
    end

    // split into channels
    assign red   = mix_q[7:5];
    assign green = mix_q[4:2];
    // two blue bits from the palette, bottom bit tied low
    assign blue  = {mix_q[1:0], 1'b0};

endmodule

// ==== rtl/colmix_top.sv ====
`include "colmix_settings.svh"

module colmix_top
    import video_pkg::*, prom_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    // PROM programming
    input  prom_addr_t prog_addr,
    input  prom_data_t prog_data,
    input  prom_sel_t  prog_sel,
    input  logic       prog_we,
    // blanking
    input  logic       hblank_n,
    input  logic       vblank_n,
    // layers
    input  bak_code_t  bak_code,
    input  obj_code_t  obj_code,
    input  obj_pix_t   obj_pix,
    input  txt_code_t  txt_code,
    input  logic       txt_valid,
    // video out
    output chan3_t     red,
    output chan3_t     green,
    output chan3_t     blue
);

    prom_addr_t rd_addr [`COLMIX_NUM_LAYERS]; // per layer read address
    logic [`COLMIX_NUM_LAYERS-1:0] prom_we;   // one-hot write enables
    layer_sel_t layer_sel;
    colour_t    pal [`COLMIX_NUM_LAYERS];     // PROM outputs

    layer_fetch i_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .bak_code  (bak_code),
        .obj_code  (obj_code),
        .obj_pix   (obj_pix),
        .txt_code  (txt_code),
        .txt_valid (txt_valid),
        .hblank_n  (hblank_n),
        .vblank_n  (vblank_n),
        .prog_sel  (prog_sel),
        .prog_we   (prog_we),
        .rd_addr   (rd_addr),
        .we        (prom_we),
        .layer_sel (layer_sel)
    );

    // bak, obj, txt palettes, all the same size
    for (genvar i = 0; i < `COLMIX_NUM_LAYERS; i++) begin : g_prom
        palette_prom i_prom (
            .clk     (clk),
            .cen     (pxl_cen),
            .rd_addr (rd_addr[i]),
            .wr_addr (prog_addr),  // shared write bus
            .data    (prog_data),
            .we      (prom_we[i]),
            .q       (pal[i])
        );
    end

    colour_priority_mix i_mix (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .vblank_n  (vblank_n),
        .layer_sel (layer_sel),
        .pal       (pal),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

endmodule

// ==== verif/colmix_chk.sv ====
`include "colmix_settings.svh"

module colmix_chk
    import video_pkg::*;
(
    input logic   clk,
    input logic   rst_n,
    input logic   pxl_cen,
    input chan3_t red,
    input chan3_t green,
    input chan3_t blue
);

    // blue lsb is tied low in the mixer
    a_blue_lsb_zero : assert property (@(posedge clk) blue[0] == 1'b0)
        else $error("blue bit 0 is not zero");

    // output register cleared while reset is held
    a_reset_black : assert property (
        @(posedge clk) !rst_n |-> (red == '0 && green == '0 && blue == '0))
        else $error("rgb outputs not zero during reset");

    // output register loads only on a strobe edge
    // so a change is seen one cycle after pxl_cen was high
    a_change_on_strobe : assert property (
        @(posedge clk) disable iff (!rst_n)
        !$past(pxl_cen) |-> $stable({red, green, blue}))
        else $error("rgb outputs changed without a pixel strobe");

endmodule

// attach to every colmix_top in the design
bind colmix_top colmix_chk i_chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .pxl_cen (pxl_cen),
    .red     (red),
    .green   (green),
    .blue    (blue)
);

// ==== verif/colmix_tb.sv ====
`include "colmix_settings.svh"

module colmix_tb
    import video_pkg::*, prom_pkg::*;
();

    localparam int STROBE_TIMEOUT = 16; // cycles, a strobe is due every 2
    localparam int STREAM_LEN     = 64; // pixels in the streaming test

    logic       clk;
    logic       rst_n;
    logic       pxl_cen;
    prom_addr_t prog_addr;
    prom_data_t prog_data;
    prom_sel_t  prog_sel;
    logic       prog_we;
    logic       hblank_n;
    logic       vblank_n;
    bak_code_t  bak_code;
    obj_code_t  obj_code;
    obj_pix_t   obj_pix;
    txt_code_t  txt_code;
    logic       txt_valid;
    chan3_t     red;
    chan3_t     green;
    chan3_t     blue;

    prom_data_t model_mem [`COLMIX_NUM_LAYERS][PROM_DEPTH]; // what each PROM should hold

    colmix_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_sel  (prog_sel),
        .prog_we   (prog_we),
        .hblank_n  (hblank_n),
        .vblank_n  (vblank_n),
        .bak_code  (bak_code),
        .obj_code  (obj_code),
        .obj_pix   (obj_pix),
        .txt_code  (txt_code),
        .txt_valid (txt_valid),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

    always #4 clk = ~clk; // period 8

    // pixel strobe on every second edge, free running through reset
    always begin
        @(posedge clk);
        #1 pxl_cen = ~pxl_cen;
    end

    // stop the run at the first error
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    // returns 1 time unit after the next strobe edge
    task automatic wait_strobe();
        int  n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk);
            seen = pxl_cen; // stable here, driven after the edge
            n++;
            if (!seen && n >= STROBE_TIMEOUT) begin
                abort_run("timeout, no pixel strobe seen within the cycle limit");
            end
        end
        #1;
    endtask

    task automatic check_colour(input string test, input colour_t exp, input colour_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAILED %s: colour expected %h, actual %h", test, exp, act));
        end
    endtask

    task automatic check_chan(input string test, input chan3_t exp, input chan3_t act);
        if (act !== exp) begin
            abort_run($sformatf("FAILED %s: blue expected %b, actual %b", test, exp, act));
        end
    endtask

    // rrr ggg bb reassembled from the pins, blue lsb checked on its own
    task automatic check_output(input string test, input colour_t exp);
        check_colour(test, exp, {red, green, blue[2:1]});
        check_chan(test, {exp[1:0], 1'b0}, blue);
    endtask

    // reference mix
    // vb picks bg at strobe N, vb_late forces black at strobe N+1
    function automatic colour_t expected_colour(
        input logic      tv,
        input obj_pix_t  pix,
        input bak_code_t bc,
        input obj_code_t oc,
        input txt_code_t tc,
        input logic      hb,
        input logic      vb,
        input logic      vb_late
    );
        colour_t c;
        c = 8'h00; // black unless a layer shows
        if (!tv) begin
            c = model_mem[TXT_IDX][{3'b000, tc[3], tc}]; // top bit doubled
        end else if (pix != 2'b00) begin
            c = model_mem[OBJ_IDX][{oc, pix}];
        end else if (hb && vb) begin
            c = model_mem[BAK_IDX][{3'b000, bc}];
        end
        if (!vb_late) begin
            c = 8'h00;
        end
        return c;
    endfunction

    // every word of every PROM gets a random value
    task automatic program_proms();
        for (int l = 0; l < `COLMIX_NUM_LAYERS; l++) begin
            for (int a = 0; a < PROM_DEPTH; a++) begin
                prog_sel  = prom_sel_t'(l);
                prog_addr = prom_addr_t'(a);
                prog_data = prom_data_t'($urandom);
                prog_we   = 1'b1;
                model_mem[l][a] = prog_data;
                @(posedge clk); // write lands on this edge
                #1;
            end
        end
        prog_we = 1'b0;
    endtask

    task automatic randomize_layers();
        bak_code = bak_code_t'($urandom);
        obj_code = obj_code_t'($urandom);
        obj_pix  = obj_pix_t'($urandom);
        txt_code = txt_code_t'($urandom);
    endtask

    // inputs held across both strobes, so vblank is the same at N and N+1
    task automatic check_held_pixel(input string test);
        colour_t exp;
        exp = expected_colour(txt_valid, obj_pix, bak_code, obj_code, txt_code,
                              hblank_n, vblank_n, vblank_n);
        wait_strobe(); // strobe N, PROM read and select
        wait_strobe(); // strobe N+1, output register
        check_output(test, exp);
    endtask

    task automatic test_reset();
        check_output("reset", 8'h00); // no strobe since reset released
    endtask

    task automatic test_text_priority();
        for (int i = 0; i < 16; i++) begin
            randomize_layers();
            txt_code  = txt_code_t'(i); // walk all text codes
            txt_valid = 1'b0;
            hblank_n  = ($urandom % 2 != 0);
            vblank_n  = 1'b1;
            check_held_pixel("text_priority");
        end
    endtask

    task automatic test_object_priority();
        for (int i = 0; i < 16; i++) begin
            randomize_layers();
            obj_pix   = obj_pix_t'(1 + $urandom % 3); // opaque only
            txt_valid = 1'b1;
            hblank_n  = ($urandom % 2 != 0);
            vblank_n  = 1'b1;
            check_held_pixel("object_priority");
        end
    endtask

    task automatic test_background_hblank();
        for (int i = 0; i < 32; i++) begin
            randomize_layers();
            bak_code  = bak_code_t'(i);
            obj_pix   = 2'b00; // sprite transparent
            txt_valid = 1'b1;
            hblank_n  = (i % 4 != 0); // every fourth in hblank
            vblank_n  = 1'b1;
            check_held_pixel("background_hblank");
        end
    endtask

    task automatic test_vblank();
        for (int i = 0; i < 16; i++) begin
            randomize_layers();
            txt_valid = ($urandom % 2 != 0);
            hblank_n  = ($urandom % 2 != 0);
            vblank_n  = 1'b0;
            check_held_pixel("vblank");
        end
    endtask

    // new pixel every strobe, results checked two strobes later
    task automatic test_streaming();
        colour_t   exp_q[$];
        logic      p_tv;
        logic      p_hb;
        logic      p_vb;
        obj_pix_t  p_pix;
        bak_code_t p_bc;
        obj_code_t p_oc;
        txt_code_t p_tc;
        p_tv  = 1'b1;
        p_hb  = 1'b0;
        p_vb  = 1'b1;
        p_pix = '0;
        p_bc  = '0;
        p_oc  = '0;
        p_tc  = '0;
        for (int i = 0; i < STREAM_LEN + 2; i++) begin
            wait_strobe();
            if (i >= 2) begin
                check_output("streaming", exp_q.pop_front()); // pixel i-2
            end
            if (i < STREAM_LEN) begin
                randomize_layers();
                txt_valid = ($urandom % 3 != 0);
                hblank_n  = ($urandom % 4 != 0);
                vblank_n  = ($urandom % 8 != 0);
            end
            // previous pixel gets blanked by the vblank level of this one
            if (i >= 1 && i <= STREAM_LEN) begin
                exp_q.push_back(expected_colour(p_tv, p_pix, p_bc, p_oc, p_tc,
                                                p_hb, p_vb, vblank_n));
            end
            p_tv  = txt_valid;
            p_hb  = hblank_n;
            p_vb  = vblank_n;
            p_pix = obj_pix;
            p_bc  = bak_code;
            p_oc  = obj_code;
            p_tc  = txt_code;
        end
    endtask

    initial begin
        void'($urandom(32'h367ca8df));
        clk       = 1'b0;
        rst_n     = 1'b0;
        pxl_cen   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        prog_sel  = '0;
        prog_we   = 1'b0;
        hblank_n  = 1'b0;
        vblank_n  = 1'b1;
        bak_code  = '0;
        obj_code  = '0;
        obj_pix   = '0;
        txt_code  = '0;
        txt_valid = 1'b1; // text hidden
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        test_reset();
        program_proms();
        test_text_priority();
        test_object_priority();
        test_background_hblank();
        test_vblank();
        test_streaming();

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+rtl
rtl/video_pkg.sv
rtl/prom_pkg.sv
rtl/layer_fetch.sv
rtl/palette_prom.sv
rtl/colour_priority_mix.sv
rtl/colmix_top.sv
verif/colmix_chk.sv
verif/colmix_tb.sv
